// ==== tcu_dot_exc.f ====
+incdir+rtl
rtl/tcu_fp_pkg.sv
rtl/tcu_xfer_pkg.sv
rtl/tcu_stage_if.sv
rtl/tcu_operand_decode.sv
rtl/tcu_special_execute.sv
rtl/tcu_result_queue.sv
rtl/tcu_dot_exc.sv
verification/tcu_dot_exc_checks.sv
verification/tcu_dot_exc_tb.sv

// ==== verification/tcu_dot_exc_tb.sv ====
// ------------------------------------------------
// Testbench for the dot-product exception lane
// Directed and seeded random requests under credit
// flow control; the checker module does the compares
// ------------------------------------------------
`timescale 1ns/100ps
`include "tcu_defines.svh"

module tcu_dot_exc_tb;

    localparam int N_REQUESTS     = 8 + 5 + 6 + 40 + 21 + 12;
    localparam int TIMEOUT_CYCLES = N_REQUESTS * 40 + 200;
    localparam int W              = `TCU_N_PAIRS * 16;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   in_valid;
    logic [2:0]             fmt;
    logic [W-1:0]           a_rows;
    logic [W-1:0]           b_cols;
    logic [31:0]            c_val;
    logic                   in_credit;
    logic                   out_valid;
    logic [2:0]             out_flags;
    logic                   out_override;
    logic [31:0]            out_value;
    logic [`TCU_EXP_W-1:0]  out_max_exp;
    logic                   out_credit = 1'b0;
    logic                   stall = 1'b0;
    int                     test_id = 0;
    int                     sent = 0;
    int                     returned = 0;
    int                     owed = 0;
    int                     cycles = 0;
    int                     tb_errors = 0;
    int                     err_before;
    int                     chk_errors;
    int                     chk_checks;
    int                     chk_pending;
    int                     chk_results;

    always #2 clk = ~clk;

    tcu_dot_exc u_dut (
        .clk(clk), .reset(reset), .in_valid(in_valid), .fmt(fmt),
        .a_rows(a_rows), .b_cols(b_cols), .c_val(c_val), .in_credit(in_credit),
        .out_valid(out_valid), .out_flags(out_flags), .out_override(out_override),
        .out_value(out_value), .out_max_exp(out_max_exp), .out_credit(out_credit)
    );

    tcu_dot_exc_checks u_chk (
        .clk(clk), .reset(reset), .in_valid(in_valid), .fmt(fmt),
        .a_rows(a_rows), .b_cols(b_cols), .c_val(c_val), .in_credit(in_credit),
        .out_valid(out_valid), .out_flags(out_flags), .out_override(out_override),
        .out_value(out_value), .out_max_exp(out_max_exp), .out_credit(out_credit),
        .test_id(test_id), .error_count(chk_errors), .check_count(chk_checks),
        .pending(chk_pending), .results(chk_results)
    );

    // Receiver hands back one credit per result after a random delay
    always @(posedge clk) begin : receiver
        int   owed_next;
        logic give;
        owed_next = owed + (out_valid ? 1 : 0);
        give      = !reset && !stall && (owed_next > 0) && ($urandom % 4 == 0);
        owed       <= reset ? 0 : owed_next - (give ? 1 : 0);
        out_credit <= give;
        if (in_credit && !reset) begin
            returned <= returned + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [15:0] finite_word(input logic bf16);
        logic [15:0] w;
        int          pick;
        w    = 16'($urandom);
        pick = $urandom % 8;
        if (bf16 ? &w[14:7] : &w[14:10]) begin
            w[14] = 1'b0;
        end
        if (pick == 0) begin
            w[14:0] = '0;
        end else if (pick == 1) begin
            w[14:7] = bf16 ? 8'd0 : {5'd0, w[9:7]};
        end
        return w;
    endfunction

    function automatic logic [31:0] finite_acc();
        logic [31:0] c;
        c = $urandom;
        if (&c[30:23]) begin
            c[30] = 1'b0;
        end
        if ($urandom % 4 == 0) begin
            c[30:23] = 8'd0;
        end
        return c;
    endfunction

    // Expects to be called right after a rising edge
    task automatic send(input logic [2:0] f, input logic [W-1:0] a,
                        input logic [W-1:0] b, input logic [31:0] c);
        while (`TCU_QUEUE_DEPTH - sent + returned == 0) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        in_valid <= 1'b1;
        fmt      <= f;
        a_rows   <= a;
        b_cols   <= b;
        c_val    <= c;
        sent++;
        @(posedge clk);
    endtask

    task automatic send_finite(input logic [2:0] f);
        logic [W-1:0] a;
        logic [W-1:0] b;
        for (int i = 0; i < `TCU_N_PAIRS; i++) begin
            a[16*i +: 16] = finite_word(f == 3'd2);
            b[16*i +: 16] = finite_word(f == 3'd2);
        end
        send(f, a, b, finite_acc());
    endtask

    task automatic start_test(input int id);
        test_id    <= id;
        err_before = chk_errors + tb_errors;
        @(posedge clk);
    endtask

    task automatic end_test();
        in_valid <= 1'b0;
        @(posedge clk);
        while (chk_pending != 0 || owed != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        assert (chk_results == sent) else begin
            tb_errors++;
            $display("%0d requests sent but %0d results came back", sent, chk_results);
        end
        $display("test %0d %s finished, %0d error(s)", test_id,
                 u_chk.name_of(test_id), chk_errors + tb_errors - err_before);
    endtask

    initial begin
        void'($urandom(32'hc45f));
        reset    = 1'b1;
        in_valid = 1'b0;
        fmt      = 3'd0;
        a_rows   = '0;
        b_cols   = '0;
        c_val    = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!out_valid && !in_credit) else begin
            tb_errors++;
            $display("out_valid or in_credit high right after reset");
        end

        start_test(1);
        send(3'd1, {16'h3C00, 16'h3C00, 16'h3C00, 16'h7E00}, {4{16'h3C00}}, 32'h0);
        send(3'd1, {16'h3C00, 16'hFC00, 16'h3C00, 16'h3C00}, {4{16'h3C00}}, 32'h0);
        send(3'd1, {4{16'h0000}}, {4{16'h4000}}, 32'h0);
        send(3'd2, {16'h7FC0, 16'h3F80, 16'h3F80, 16'h3F80}, {4{16'h3F80}}, 32'h0);
        send(3'd2, {16'h3F80, 16'h7F80, 16'h3F80, 16'h3F80}, {4{16'h4000}}, 32'h0);
        send(3'd2, {4{16'h8000}}, {4{16'h3F80}}, 32'h3F80_0000);
        send(3'd1, {4{16'h3C00}}, {4{16'h3C00}}, 32'h7F80_0001);
        send(3'd2, {4{16'h3F80}}, {4{16'h3F80}}, 32'hFF80_0000);
        end_test();

        start_test(2);
        send(3'd1, {16'h3C00, 16'h3C00, 16'h3C00, 16'h7C00},
             {16'h3C00, 16'h3C00, 16'h3C00, 16'h0000}, 32'h0);
        send(3'd2, {16'h3F80, 16'h3F80, 16'hFF80, 16'h7F80}, {4{16'h3F80}}, 32'h0);
        send(3'd1, {16'h3C00, 16'h3C00, 16'h3C00, 16'h7C00}, {4{16'h3C00}}, 32'hFF80_0000);
        send(3'd2, {16'h3F80, 16'hFF80, 16'h3F80, 16'hFF80}, {4{16'h3F80}}, 32'hFF80_0000);
        send(3'd1, {16'h7C00, 16'h3C00, 16'hFC00, 16'h3C00},
             {16'h3C00, 16'h3C00, 16'hBC00, 16'h3C00}, 32'h0);
        end_test();

        start_test(3);
        send(3'd0, {2{$urandom}}, {2{$urandom}}, $urandom);
        for (int f = 3; f < 8; f++) begin
            send(3'(f), {$urandom, $urandom}, {$urandom, $urandom}, $urandom);
        end
        end_test();

        start_test(4);
        send(3'd1, '0, '0, 32'h0);
        send(3'd1, {4{16'h0001}}, {4{16'h0001}}, 32'h0);
        for (int i = 0; i < 38; i++) begin
            send_finite(($urandom % 2 == 0) ? 3'd1 : 3'd2);
        end
        end_test();

        start_test(5);
        send_finite(3'd2);
        in_valid <= 1'b0;
        repeat (8) @(posedge clk);
        for (int i = 0; i < 20; i++) begin
            send(3'd1 + 3'($urandom % 2), {$urandom, $urandom}, {$urandom, $urandom}, $urandom);
        end
        end_test();

        start_test(6);
        stall <= 1'b1;
        repeat (8) send_finite(3'd1);
        in_valid <= 1'b0;
        repeat (30) @(posedge clk);
        assert (`TCU_QUEUE_DEPTH - sent + returned == 0 && !out_valid) else begin
            tb_errors++;
            $display("input credits not all in use while the receiver stalls");
        end
        stall <= 1'b0;
        repeat (4) send_finite(3'd2);
        end_test();

        $display("tests: 6, checks: %0d, errors: %0d", chk_checks, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verification/tcu_dot_exc_checks.sv ====
// ------------------------------------------------
// Result checker for the dot-product exception lane
// Builds expected results on accept and compares
// each output; also checks latency and credit use
// ------------------------------------------------
`timescale 1ns/100ps
`include "tcu_defines.svh"

module tcu_dot_exc_checks (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  logic [2:0]                     fmt,
    input  logic [`TCU_N_PAIRS*16-1:0]     a_rows,
    input  logic [`TCU_N_PAIRS*16-1:0]     b_cols,
    input  logic [31:0]                    c_val,
    input  logic                           in_credit,
    input  logic                           out_valid,
    input  logic [2:0]                     out_flags,
    input  logic                           out_override,
    input  logic [31:0]                    out_value,
    input  logic [`TCU_EXP_W-1:0]          out_max_exp,
    input  logic                           out_credit,
    input  int                             test_id,
    output int                             error_count,
    output int                             check_count,
    output int                             pending,
    output int                             results
);

    typedef struct packed {
        logic [2:0]              flags;
        logic                    ovr;
        logic [31:0]             value;
        logic [`TCU_EXP_W-1:0]   max_exp;
    } result_rec_t;

    result_rec_t exp_q [$];
    int          acc_q [$];
    logic        timed_q [$];
    int          cycle = 0;
    int          pops = 0;
    int          credits_back = 0;
    int          errors = 0;
    int          checks = 0;
    int          got_count = 0;

    function automatic string name_of(input int id);
        case (id)
            1:       return "fp16/bf16 specials";
            2:       return "generated NaN";
            3:       return "unsupported format";
            4:       return "alignment exponent";
            5:       return "ordering and latency";
            6:       return "credit rules";
            default: return "reset";
        endcase
    endfunction

    function automatic void half_class(input logic [15:0] w, input logic bf16,
                                       output logic nan, output logic inf,
                                       output logic zero, output int e);
        int   field;
        logic frac_nz;
        logic ones;
        field   = bf16 ? int'(w[14:7]) : int'(w[14:10]);
        frac_nz = bf16 ? |w[6:0] : |w[9:0];
        ones    = bf16 ? &w[14:7] : &w[14:10];
        nan     = ones & frac_nz;
        inf     = ones & ~frac_nz;
        zero    = (w[14:0] == 15'd0);
        // Subnormals align as exponent 1, fp16 bias moves from 15 to 127
        e = (field == 0) ? 1 : field;
        e = bf16 ? e : e + 112;
    endfunction

    function automatic result_rec_t expect_result(input logic [2:0] f,
                                                  input logic [`TCU_N_PAIRS*16-1:0] a,
                                                  input logic [`TCU_N_PAIRS*16-1:0] b,
                                                  input logic [31:0] c);
        result_rec_t r;
        logic        bad;
        logic        nan;
        logic        pos_inf;
        logic        neg_inf;
        logic        an, ai, az, bn, bi, bz;
        logic        c_nan;
        logic        c_inf;
        int          ae, be, mx;
        bad     = (f != 3'd1) && (f != 3'd2);
        c_nan   = (&c[30:23]) & (|c[22:0]);
        c_inf   = (&c[30:23]) & ~(|c[22:0]);
        nan     = bad | c_nan;
        pos_inf = c_inf & ~c[31];
        neg_inf = c_inf & c[31];
        mx      = 0;
        if (!c_nan && !c_inf && (c[30:0] != 31'd0)) begin
            mx = (c[30:23] == 8'd0) ? 1 : int'(c[30:23]);
        end
        for (int i = 0; i < `TCU_N_PAIRS && !bad; i++) begin
            half_class(a[16*i +: 16], f == 3'd2, an, ai, az, ae);
            half_class(b[16*i +: 16], f == 3'd2, bn, bi, bz, be);
            if (an || bn || (ai && bz) || (az && bi)) begin
                nan = 1'b1;
            end
            if ((ai || bi) && !((ai && bz) || (az && bi))) begin
                neg_inf = neg_inf | (a[16*i+15] ^ b[16*i+15]);
                pos_inf = pos_inf | ~(a[16*i+15] ^ b[16*i+15]);
            end
            // Products below fp32 range never beat the floor of 0
            if (!(an || ai || az || bn || bi || bz) && (ae + be - 127 > mx)) begin
                mx = ae + be - 127;
            end
        end
        nan       = nan | (pos_inf & neg_inf);
        r.flags   = {neg_inf & ~pos_inf, nan, (pos_inf | neg_inf) & ~nan};
        r.ovr     = nan | pos_inf | neg_inf;
        r.value   = nan ? 32'h7FC0_0000 : !r.ovr ? 32'h0 :
                    neg_inf ? 32'hFF80_0000 : 32'h7F80_0000;
        r.max_exp = `TCU_EXP_W'(mx);
        return r;
    endfunction

    always @(posedge clk) begin : monitor
        result_rec_t want;
        result_rec_t got;
        int          t0;
        logic        timed;
        if (reset) begin
            exp_q.delete();
            acc_q.delete();
            timed_q.delete();
            pops         = 0;
            credits_back = 0;
        end else begin
            cycle++;
            assert (in_credit == out_valid) else begin
                errors++;
                $display("in_credit and out_valid differ at cycle %0d", cycle);
            end
            if (out_valid) begin
                assert (pops < `TCU_OUT_CREDITS + credits_back) else begin
                    errors++;
                    $display("out_valid sent with no output credit left at cycle %0d", cycle);
                end
                pops++;
                got_count++;
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("result arrived with no request pending at cycle %0d", cycle);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    t0   = acc_q.pop_front();
                    timed = timed_q.pop_front();
                    got  = {out_flags, out_override, out_value, out_max_exp};
                    checks++;
                    assert (got == want) else begin
                        errors++;
                        $display("FAIL %s: expected flags=%b override=%b value=%h max_exp=%0d, %s",
                                 name_of(test_id), want.flags, want.ovr, want.value,
                                 want.max_exp, $sformatf("actual flags=%b override=%b %s",
                                 got.flags, got.ovr, $sformatf("value=%h max_exp=%0d",
                                 got.value, got.max_exp)));
                    end
                    if (timed) begin
                        checks++;
                        assert (cycle - t0 == 3) else begin
                            errors++;
                            $display("FAIL %s: expected latency 3, actual %0d",
                                     name_of(test_id), cycle - t0);
                        end
                    end
                end
            end
            if (out_credit) begin
                credits_back++;
            end
            // Idle lane with a free output credit must answer in 3 cycles
            if (in_valid) begin
                timed_q.push_back(exp_q.size() == 0 &&
                                  (`TCU_OUT_CREDITS - pops + credits_back) > 0);
                exp_q.push_back(expect_result(fmt, a_rows, b_cols, c_val));
                acc_q.push_back(cycle);
            end
        end
        error_count <= errors;
        check_count <= checks;
        pending     <= exp_q.size();
        results     <= got_count;
    end

endmodule

// ==== rtl/tcu_dot_exc.sv ====
// ------------------------------------------------
// Top level of the dot-product exception lane
// Plain ports with credit flow control on both
// sides; three stages joined by the stage links
// ------------------------------------------------
`timescale 1ns/100ps
`include "tcu_defines.svh"

module tcu_dot_exc
    import tcu_fp_pkg::*;
    import tcu_xfer_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  logic [2:0]                     fmt,
    input  logic [`TCU_N_PAIRS*16-1:0]     a_rows,
    input  logic [`TCU_N_PAIRS*16-1:0]     b_cols,
    input  logic [31:0]                    c_val,
    output logic                           in_credit,
    output logic                           out_valid,
    output logic [2:0]                     out_flags,
    output logic                           out_override,
    output logic [31:0]                    out_value,
    output logic [`TCU_EXP_W-1:0]          out_max_exp,
    input  logic                           out_credit
);

    tcu_half_u [`TCU_N_PAIRS-1:0]   a_words;
    tcu_half_u [`TCU_N_PAIRS-1:0]   b_words;
    tcu_fp32_s                      c_word;
    tcu_result_s                    result;

    tcu_dec_if dec_link ();
    tcu_exe_if exe_link ();

    assign a_words = a_rows;
    assign b_words = b_cols;
    assign c_word  = c_val;

    tcu_operand_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .fmt      (tcu_fmt_e'(fmt)),
        .a_rows   (a_words),
        .b_cols   (b_words),
        .c_val    (c_word),
        .dec      (dec_link.src)
    );

    tcu_special_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .dec   (dec_link.dst),
        .exe   (exe_link.src)
    );

    tcu_result_queue u_result (
        .clk        (clk),
        .reset      (reset),
        .exe        (exe_link.dst),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (result),
        .in_credit  (in_credit)
    );

    // Flags as {sign, nan, inf}
    assign out_flags    = {result.sign, result.nan, result.inf};
    assign out_override = result.override;
    assign out_value    = result.value;
    assign out_max_exp  = result.max_exp;

endmodule

// ==== rtl/tcu_result_queue.sv ====
// ------------------------------------------------
// Reduction and result queueing stage
// Folds products and accumulator into final flags,
// override word and max exponent, then queues them
// and runs the input and output credit loops
// ------------------------------------------------
`timescale 1ns/100ps
`include "tcu_defines.svh"

module tcu_result_queue
    import tcu_fp_pkg::*;
    import tcu_xfer_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    tcu_exe_if.dst         exe,
    input  logic           out_credit,
    output logic           out_valid,
    output tcu_result_s    out_result,
    output logic           in_credit
);

    localparam int PTR_W = $clog2(`TCU_QUEUE_DEPTH);

    logic                        any_nan;
    logic                        any_inf;
    logic                        has_pos_inf;
    logic                        has_neg_inf;
    logic                        c_counts;
    logic [`TCU_EXP_W-1:0]       max_exp;
    tcu_result_s                 rec_d;

    tcu_result_s                 mem [`TCU_QUEUE_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [`TCU_CREDIT_W-1:0]    count;
    logic [`TCU_CREDIT_W-1:0]    out_cnt;
    logic                        push;
    logic                        pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`TCU_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Accumulator joins the search only if nonzero and not special
    assign c_counts = ~(exe.c_cls.zero | exe.c_cls.nan | exe.c_cls.inf);

    always_comb begin
        any_nan     = exe.bad_fmt | exe.c_cls.nan;
        any_inf     = exe.c_cls.inf;
        has_pos_inf = exe.c_cls.inf & ~exe.c_cls.sign;
        has_neg_inf = exe.c_cls.inf & exe.c_cls.sign;
        max_exp     = c_counts ? exe.c_exp : '0;
        for (int i = 0; i < `TCU_N_PAIRS; i++) begin
            any_nan     = any_nan | exe.prods[i].nan_gen;
            any_inf     = any_inf | exe.prods[i].inf;
            has_pos_inf = has_pos_inf | (exe.prods[i].inf & ~exe.prods[i].sign);
            has_neg_inf = has_neg_inf | (exe.prods[i].inf & exe.prods[i].sign);
            if (exe.prods[i].finite_nz && (exe.prods[i].exp > max_exp)) begin
                max_exp = exe.prods[i].exp;
            end
        end

        // Opposite infinities cancel into a NaN
        rec_d.nan      = any_nan | (has_pos_inf & has_neg_inf);
        rec_d.inf      = any_inf & ~rec_d.nan;
        rec_d.sign     = has_neg_inf & ~has_pos_inf;
        rec_d.override = rec_d.nan | rec_d.inf;
        if (rec_d.nan) begin
            rec_d.value = TCU_CANON_NAN;
        end else if (rec_d.inf) begin
            rec_d.value = rec_d.sign ? TCU_NEG_INF : TCU_POS_INF;
        end else begin
            rec_d.value = '0;
        end
        rec_d.max_exp = max_exp;
    end

    // Sender credits guarantee a free slot on every push
    assign push       = exe.valid;
    assign pop        = (count != '0) && (out_cnt != '0);
    assign out_valid  = pop;
    assign in_credit  = pop;
    assign out_result = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rec_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            out_cnt <= `TCU_CREDIT_W'(`TCU_OUT_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Returned credit and a send in one cycle cancel out
            case ({out_credit, pop})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

endmodule

// ==== rtl/tcu_special_execute.sv ====
// ------------------------------------------------
// Product and special-case stage
// Per pair: inf times zero, product inf and sign,
// nonzero-finite flag and aligned product exponent
// ------------------------------------------------
`timescale 1ns/100ps
`include "tcu_defines.svh"

module tcu_special_execute
    import tcu_xfer_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    tcu_dec_if.dst  dec,
    tcu_exe_if.src  exe
);

    localparam int FP32_BIAS = 127;

    tcu_prod_s [`TCU_N_PAIRS-1:0] prods_d;

    for (genvar i = 0; i < `TCU_N_PAIRS; i++) begin : g_prod
        tcu_pair_s               p;
        logic                    inf_x_zero;
        logic                    special;
        logic [`TCU_EXP_W:0]     exp_sum;
        logic [`TCU_EXP_W-1:0]   exp_aligned;

        assign p = dec.pairs[i];

        assign inf_x_zero = (p.a_cls.inf & p.b_cls.zero) | (p.a_cls.zero & p.b_cls.inf);

        assign special = p.a_cls.zero | p.a_cls.nan | p.a_cls.inf |
                         p.b_cls.zero | p.b_cls.nan | p.b_cls.inf;

        // One bit wider, the sum of two rebased exponents reaches 508
        assign exp_sum = {1'b0, p.a_exp} + {1'b0, p.b_exp};

        // Products below fp32 range align to exponent 0
        assign exp_aligned = (exp_sum <= (`TCU_EXP_W+1)'(FP32_BIAS)) ? '0 :
                             `TCU_EXP_W'(exp_sum - (`TCU_EXP_W+1)'(FP32_BIAS));

        always_comb begin
            prods_d[i].nan_gen   = p.a_cls.nan | p.b_cls.nan | inf_x_zero;
            prods_d[i].inf       = (p.a_cls.inf | p.b_cls.inf) & ~inf_x_zero;
            prods_d[i].sign      = p.a_cls.sign ^ p.b_cls.sign;
            prods_d[i].finite_nz = ~special;
            prods_d[i].exp       = exp_aligned;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= dec.valid;
        end
    end

    // Accumulator info passes through unchanged
    always_ff @(posedge clk) begin
        exe.bad_fmt <= dec.bad_fmt;
        exe.prods   <= prods_d;
        exe.c_cls   <= dec.c_cls;
        exe.c_exp   <= dec.c_exp;
    end

endmodule

// ==== rtl/tcu_operand_decode.sv ====
// ------------------------------------------------
// Operand classification stage
// Reads each word in the requested format, sets its
// class bits and rebases its exponent to fp32 bias
// ------------------------------------------------
`timescale 1ns/100ps
`include "tcu_defines.svh"

module tcu_operand_decode
    import tcu_fp_pkg::*;
    import tcu_xfer_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             in_valid,
    input  tcu_fmt_e                         fmt,
    input  tcu_half_u [`TCU_N_PAIRS-1:0]     a_rows,
    input  tcu_half_u [`TCU_N_PAIRS-1:0]     b_cols,
    input  tcu_fp32_s                        c_val,
    tcu_dec_if.src                           dec
);

    // fp16 bias 15 to fp32 bias 127
    localparam int FP16_REBASE = 112;

    logic                           is_bf16;
    logic                           bad_fmt_d;
    tcu_pair_s [`TCU_N_PAIRS-1:0]   pairs_d;
    tcu_class_s                     c_cls_d;
    logic [`TCU_EXP_W-1:0]          c_exp_d;

    function automatic tcu_class_s classify(input tcu_half_u w, input logic bf16);
        tcu_class_s cls;
        logic       exp_ones;
        logic       frac_nz;
        exp_ones = bf16 ? (&w.bf16.exp) : (&w.fp16.exp);
        frac_nz  = bf16 ? (|w.bf16.frac) : (|w.fp16.frac);
        // Sign sits in bit 15 for both views
        cls.sign = w.fp16.sign;
        cls.nan  = exp_ones & frac_nz;
        cls.inf  = exp_ones & ~frac_nz;
        cls.zero = ~|w[14:0];
        return cls;
    endfunction

    // Subnormal exponent field counts as 1
    function automatic logic [`TCU_EXP_W-1:0] rebase(input tcu_half_u w, input logic bf16);
        logic [`TCU_EXP_W-1:0] e;
        if (bf16) begin
            e = (w.bf16.exp == '0) ? `TCU_EXP_W'(1) : `TCU_EXP_W'(w.bf16.exp);
        end else begin
            e = (w.fp16.exp == '0) ? `TCU_EXP_W'(1) : `TCU_EXP_W'(w.fp16.exp);
            e = e + `TCU_EXP_W'(FP16_REBASE);
        end
        return e;
    endfunction

    always_comb begin
        is_bf16   = (fmt == FMT_BF16);
        bad_fmt_d = (fmt != FMT_FP16) && (fmt != FMT_BF16);
        for (int i = 0; i < `TCU_N_PAIRS; i++) begin
            if (bad_fmt_d) begin
                // Operands read as zero, NaN is raised from bad_fmt later
                pairs_d[i]            = '0;
                pairs_d[i].a_cls.zero = 1'b1;
                pairs_d[i].b_cls.zero = 1'b1;
            end else begin
                pairs_d[i].a_cls = classify(a_rows[i], is_bf16);
                pairs_d[i].b_cls = classify(b_cols[i], is_bf16);
                pairs_d[i].a_exp = rebase(a_rows[i], is_bf16);
                pairs_d[i].b_exp = rebase(b_cols[i], is_bf16);
            end
        end
        c_cls_d.sign = c_val.sign;
        c_cls_d.nan  = (&c_val.exp) & (|c_val.frac);
        c_cls_d.inf  = (&c_val.exp) & ~(|c_val.frac);
        c_cls_d.zero = (c_val.exp == '0) && (c_val.frac == '0);
        c_exp_d      = (c_val.exp == '0) ? `TCU_EXP_W'(1) : `TCU_EXP_W'(c_val.exp);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec.bad_fmt <= bad_fmt_d;
        dec.pairs   <= pairs_d;
        dec.c_cls   <= c_cls_d;
        dec.c_exp   <= c_exp_d;
    end

endmodule

// ==== rtl/tcu_stage_if.sv ====
// ------------------------------------------------
// Stage links of the lane, decode to execute and
// execute to result; no ready, since every request
// already owns a result queue slot
// ------------------------------------------------
`timescale 1ns/100ps
`include "tcu_defines.svh"

interface tcu_dec_if import tcu_fp_pkg::*, tcu_xfer_pkg::*; ();

    logic                               valid;
    logic                               bad_fmt;
    tcu_pair_s [`TCU_N_PAIRS-1:0]       pairs;
    tcu_class_s                         c_cls;
    logic [`TCU_EXP_W-1:0]              c_exp;

    modport src (output valid, output bad_fmt, output pairs, output c_cls, output c_exp);
    modport dst (input valid, input bad_fmt, input pairs, input c_cls, input c_exp);

endinterface

interface tcu_exe_if import tcu_fp_pkg::*, tcu_xfer_pkg::*; ();

    logic                               valid;
    logic                               bad_fmt;
    tcu_prod_s [`TCU_N_PAIRS-1:0]       prods;
    tcu_class_s                         c_cls;
    logic [`TCU_EXP_W-1:0]              c_exp;

    modport src (output valid, output bad_fmt, output prods, output c_cls, output c_exp);
    modport dst (input valid, input bad_fmt, input prods, input c_cls, input c_exp);

endinterface

// ==== rtl/tcu_xfer_pkg.sv ====
// ------------------------------------------------
// Records passed between the lane's stages
// Decode emits pairs, execute emits products and
// the result stage queues result records
// ------------------------------------------------
`include "tcu_defines.svh"

package tcu_xfer_pkg;

    import tcu_fp_pkg::*;

    // Classified operand pair, exponents rebased to fp32 bias
    typedef struct packed {
        tcu_class_s                a_cls;
        tcu_class_s                b_cls;
        logic [`TCU_EXP_W-1:0]     a_exp;
        logic [`TCU_EXP_W-1:0]     b_exp;
    } tcu_pair_s;

    // Product summary, nan_gen covers NaN operands and inf times zero
    typedef struct packed {
        logic                      nan_gen;
        logic                      inf;
        logic                      sign;
        logic                      finite_nz;
        logic [`TCU_EXP_W-1:0]     exp;
    } tcu_prod_s;

    typedef struct packed {
        logic                      sign;
        logic                      nan;
        logic                      inf;
        logic                      override;
        logic [31:0]               value;
        logic [`TCU_EXP_W-1:0]     max_exp;
    } tcu_result_s;

endpackage

// ==== rtl/tcu_fp_pkg.sv ====
// ------------------------------------------------
// Floating-point format types for the lane
// Operand views, fp32 fields, class record and the
// fp32 words used to override the datapath
// ------------------------------------------------
package tcu_fp_pkg;

    // Only codes 1 and 2 are supported, the rest flag bad_fmt
    typedef enum logic [2:0] {
        FMT_FP16 = 3'd1,
        FMT_BF16 = 3'd2
    } tcu_fmt_e;

    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] frac;
    } tcu_fp16_s;

    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [6:0] frac;
    } tcu_bf16_s;

    // One operand word, decoded by the request format
    typedef union packed {
        tcu_fp16_s fp16;
        tcu_bf16_s bf16;
    } tcu_half_u;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } tcu_fp32_s;

    typedef struct packed {
        logic sign;
        logic nan;
        logic inf;
        logic zero;
    } tcu_class_s;

    // Override words
    localparam logic [31:0] TCU_CANON_NAN = 32'h7FC0_0000;
    localparam logic [31:0] TCU_POS_INF   = 32'h7F80_0000;
    localparam logic [31:0] TCU_NEG_INF   = 32'hFF80_0000;

endpackage

// ==== rtl/tcu_defines.svh ====
// ------------------------------------------------
// Sizing macros for the dot-product exception lane
// Include in any file that sizes ports, queues or
// credit counters of the lane
// ------------------------------------------------
`ifndef TCU_DEFINES_SVH
`define TCU_DEFINES_SVH

// Operand pairs per request
`define TCU_N_PAIRS 4

// Result queue slots, also the input credits after reset
`define TCU_QUEUE_DEPTH 4

// Output credits held toward the receiver after reset
`define TCU_OUT_CREDITS 4

`define TCU_CREDIT_W 3

// Aligned exponent width, fp32 bias
`define TCU_EXP_W 9

`endif
